// ==== design/mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

    // Instruction word field widths
    localparam int opcode_w     = 6;
    localparam int funct_w      = 6;
    localparam int reg_addr_w   = 5;
    localparam int shamt_w      = 5;
    localparam int imm_w        = 16;
    localparam int jump_index_w = 26;

    // Primary opcodes kept in this subset, R-type is zero
    typedef enum logic [opcode_w-1:0] {
        op_rtype = 6'h00,
        op_j     = 6'h02,
        op_beq   = 6'h04,
        op_bne   = 6'h05,
        op_addiu = 6'h09,
        op_slti  = 6'h0a,
        op_andi  = 6'h0c,
        op_ori   = 6'h0d,
        op_xori  = 6'h0e,
        op_lui   = 6'h0f,
        op_lw    = 6'h23,
        op_sw    = 6'h2b
    } opcode_t;

    // R-type function codes
    typedef enum logic [funct_w-1:0] {
        fn_sll  = 6'h00,
        fn_srl  = 6'h02,
        fn_sra  = 6'h03,
        fn_jr   = 6'h08,
        fn_addu = 6'h21,
        fn_subu = 6'h23,
        fn_and  = 6'h24,
        fn_or   = 6'h25,
        fn_xor  = 6'h26,
        fn_slt  = 6'h2a,
        fn_sltu = 6'h2b
    } funct_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_slt,
        alu_sltu, alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_t;

endpackage

`default_nettype wire

// ==== design/cpu_bus_pkg.sv ====
`default_nettype none

package cpu_bus_pkg;

    // Word and address width of the processor and its bus
    localparam int data_w = 32;

    // One byte enable per byte lane
    localparam int byte_en_w = data_w / 8;

    // Word accesses only, so every lane is always enabled
    localparam logic [byte_en_w-1:0] byte_en_full = '1;

    // Multicycle sequencing
    typedef enum logic [1:0] {
        st_fetch  = 2'd0,
        st_exec   = 2'd1,
        st_mem    = 2'd2,
        st_halted = 2'd3
    } state_t;

endpackage

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none

module alu (
    input  mips_isa_pkg::alu_op_t              op,
    input  logic [cpu_bus_pkg::data_w-1:0]     a,
    input  logic [cpu_bus_pkg::data_w-1:0]     b,
    input  logic [mips_isa_pkg::shamt_w-1:0]   shamt,
    output logic [cpu_bus_pkg::data_w-1:0]     result
);

    import mips_isa_pkg::*;
    import cpu_bus_pkg::*;

    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt   = ($signed(a) < $signed(b));
    assign unsigned_lt = (a < b);

    always_comb begin
        case (op)
            // Add and subtract wrap, no overflow trap
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            alu_slt:  result = {{(data_w-1){1'b0}}, signed_lt};
            alu_sltu: result = {{(data_w-1){1'b0}}, unsigned_lt};
            alu_sll:  result = b << shamt;
            alu_srl:  result = b >> shamt;
            alu_sra:  result = $signed(b) >>> shamt;
            // Immediate into the upper half, lower half zero
            alu_lui:  result = {b[imm_w-1:0], {(data_w-imm_w){1'b0}}};
            default:  result = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/reg_file.sv ====
`default_nettype none

module reg_file (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] rs_addr,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] rt_addr,
    input  logic                                we,
    input  logic [mips_isa_pkg::reg_addr_w-1:0] waddr,
    input  logic [cpu_bus_pkg::data_w-1:0]      wdata,
    output logic [cpu_bus_pkg::data_w-1:0]      rs_data,
    output logic [cpu_bus_pkg::data_w-1:0]      rt_data,
    output logic [cpu_bus_pkg::data_w-1:0]      v0
);

    import mips_isa_pkg::*;
    import cpu_bus_pkg::*;

    logic [data_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Register zero is never written, so it stays at its reset value
    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0      = regs[2];

endmodule

`default_nettype wire

// ==== design/pc_unit.sv ====
`default_nettype none

module pc_unit #(
    parameter logic [cpu_bus_pkg::data_w-1:0] reset_vector = 32'hBFC0_0000
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  advance,
    input  mips_isa_pkg::opcode_t                 op,
    input  mips_isa_pkg::funct_t                  funct,
    input  logic [cpu_bus_pkg::data_w-1:0]        rs_data,
    input  logic [cpu_bus_pkg::data_w-1:0]        rt_data,
    input  logic [mips_isa_pkg::imm_w-1:0]        imm,
    input  logic [mips_isa_pkg::jump_index_w-1:0] jump_index,
    output logic [cpu_bus_pkg::data_w-1:0]        pc,
    output logic [cpu_bus_pkg::data_w-1:0]        next_pc
);

    import mips_isa_pkg::*;
    import cpu_bus_pkg::*;

    logic [data_w-1:0] pc_plus4;
    logic [data_w-1:0] branch_target;
    logic [data_w-1:0] jump_target;
    logic [data_w-1:0] taken_target;
    logic [data_w-1:0] pending_target;
    logic              taken;
    logic              pending;

    assign pc_plus4      = pc + 32'd4;
    assign branch_target = pc_plus4 + {{(data_w-imm_w-2){imm[imm_w-1]}}, imm, 2'b00};
    // J stays inside the 256 MB region of the delay slot
    assign jump_target   = {pc_plus4[data_w-1:data_w-4], jump_index, 2'b00};

    always_comb begin
        taken        = 1'b0;
        taken_target = branch_target;
        case (op)
            op_beq: taken = (rs_data == rt_data);
            op_bne: taken = (rs_data != rt_data);
            op_j: begin
                taken        = 1'b1;
                taken_target = jump_target;
            end
            op_rtype: begin
                if (funct == fn_jr) begin
                    taken        = 1'b1;
                    taken_target = rs_data;
                end
            end
            default: ;
        endcase
    end

    // A taken transfer applies one advance later, after the delay slot
    assign next_pc = pending ? pending_target : pc_plus4;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc      <= reset_vector;
            pending <= 1'b0;
        end else if (advance) begin
            pc      <= next_pc;
            pending <= taken;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && taken) begin
            pending_target <= taken_target;
        end
    end

endmodule

`default_nettype wire

// ==== design/cpu_control.sv ====
`default_nettype none

module cpu_control (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  waitrequest,
    input  logic [cpu_bus_pkg::data_w-1:0]        readdata,
    input  logic [cpu_bus_pkg::data_w-1:0]        pc,
    input  logic [cpu_bus_pkg::data_w-1:0]        next_pc,
    input  logic [cpu_bus_pkg::data_w-1:0]        rt_data,
    input  logic [cpu_bus_pkg::data_w-1:0]        alu_result,
    output logic                                  active,
    output logic                                  read,
    output logic                                  write,
    output logic [cpu_bus_pkg::data_w-1:0]        address,
    output logic [cpu_bus_pkg::data_w-1:0]        writedata,
    output logic [cpu_bus_pkg::byte_en_w-1:0]     byteenable,
    output logic [mips_isa_pkg::reg_addr_w-1:0]   rs_addr,
    output logic [mips_isa_pkg::reg_addr_w-1:0]   rt_addr,
    output logic                                  rf_we,
    output logic [mips_isa_pkg::reg_addr_w-1:0]   rf_waddr,
    output logic [cpu_bus_pkg::data_w-1:0]        rf_wdata,
    output mips_isa_pkg::alu_op_t                 alu_op,
    output logic [cpu_bus_pkg::data_w-1:0]        alu_b,
    output logic [mips_isa_pkg::shamt_w-1:0]      shamt,
    output logic                                  pc_advance,
    output mips_isa_pkg::opcode_t                 branch_op,
    output mips_isa_pkg::funct_t                  funct,
    output logic [mips_isa_pkg::imm_w-1:0]        imm,
    output logic [mips_isa_pkg::jump_index_w-1:0] jump_index
);

    import mips_isa_pkg::*;
    import cpu_bus_pkg::*;

    state_t                state;
    state_t                state_next;
    logic [data_w-1:0]     ir;
    opcode_t               opcode;
    logic [reg_addr_w-1:0] rd_addr;
    logic [data_w-1:0]     imm_sext;
    logic [data_w-1:0]     imm_zext;
    logic                  is_load;
    logic                  is_store;
    logic                  alu_writes;
    logic                  dest_rd;

    // Instruction fields, all taken from the latched word
    assign opcode     = opcode_t'(ir[31:26]);
    assign funct      = funct_t'(ir[5:0]);
    assign rs_addr    = ir[25:21];
    assign rt_addr    = ir[20:16];
    assign rd_addr    = ir[15:11];
    assign shamt      = ir[10:6];
    assign imm        = ir[15:0];
    assign jump_index = ir[25:0];
    assign branch_op  = opcode;

    assign imm_sext = {{(data_w-imm_w){imm[imm_w-1]}}, imm};
    assign imm_zext = {{(data_w-imm_w){1'b0}}, imm};
    assign is_load  = (opcode == op_lw);
    assign is_store = (opcode == op_sw);

    always_comb begin
        alu_op     = alu_add;
        alu_b      = rt_data;
        alu_writes = 1'b0;
        dest_rd    = 1'b0;
        case (opcode)
            op_rtype: begin
                dest_rd    = 1'b1;
                alu_writes = (funct != fn_jr);
                case (funct)
                    fn_subu: alu_op = alu_sub;
                    fn_and:  alu_op = alu_and;
                    fn_or:   alu_op = alu_or;
                    fn_xor:  alu_op = alu_xor;
                    fn_slt:  alu_op = alu_slt;
                    fn_sltu: alu_op = alu_sltu;
                    fn_sll:  alu_op = alu_sll;
                    fn_srl:  alu_op = alu_srl;
                    fn_sra:  alu_op = alu_sra;
                    default: alu_op = alu_add;
                endcase
            end
            op_addiu: begin
                alu_b      = imm_sext;
                alu_writes = 1'b1;
            end
            op_slti: begin
                alu_op     = alu_slt;
                alu_b      = imm_sext;
                alu_writes = 1'b1;
            end
            op_andi: begin
                alu_op     = alu_and;
                alu_b      = imm_zext;
                alu_writes = 1'b1;
            end
            op_ori: begin
                alu_op     = alu_or;
                alu_b      = imm_zext;
                alu_writes = 1'b1;
            end
            op_xori: begin
                alu_op     = alu_xor;
                alu_b      = imm_zext;
                alu_writes = 1'b1;
            end
            op_lui: begin
                alu_op     = alu_lui;
                alu_b      = imm_zext;
                alu_writes = 1'b1;
            end
            // Effective address is base plus sign-extended offset
            op_lw, op_sw: alu_b = imm_sext;
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            st_fetch: begin
                if (!waitrequest) state_next = st_exec;
            end
            st_exec: begin
                if (is_load || is_store) begin
                    state_next = st_mem;
                end else if (next_pc == '0) begin
                    state_next = st_halted;
                end else begin
                    state_next = st_fetch;
                end
            end
            st_mem: begin
                // The pc already advanced in EXEC, so it is the next fetch address
                if (!waitrequest) state_next = (pc == '0) ? st_halted : st_fetch;
            end
            default: state_next = st_halted;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_fetch;
        end else begin
            state <= state_next;
        end
    end

    // Latch the fetched word when the read completes
    always_ff @(posedge clk) begin
        if (state == st_fetch && !waitrequest) begin
            ir <= readdata;
        end
    end

    assign active     = (state != st_halted);
    assign pc_advance = (state == st_exec);

    // Bus strobes, held steady through wait states
    assign read       = (state == st_fetch) || (state == st_mem && is_load);
    assign write      = (state == st_mem) && is_store;
    assign address    = (state == st_mem) ? alu_result : pc;
    assign writedata  = rt_data;
    assign byteenable = (read || write) ? byte_en_full : '0;

    assign rf_we    = (state == st_exec && alu_writes) ||
                      (state == st_mem && is_load && !waitrequest);
    assign rf_waddr = dest_rd ? rd_addr : rt_addr;
    assign rf_wdata = (state == st_mem) ? readdata : alu_result;

endmodule

`default_nettype wire

// ==== design/mips_cpu_bus.sv ====
`default_nettype none

module mips_cpu_bus #(
    parameter logic [cpu_bus_pkg::data_w-1:0] reset_vector = 32'hBFC0_0000
) (
    input  logic                                clk,
    input  logic                                reset,
    output logic                                active,
    output logic [cpu_bus_pkg::data_w-1:0]      register_v0,

    // Memory-mapped bus master
    output logic [cpu_bus_pkg::data_w-1:0]      address,
    output logic                                write,
    output logic                                read,
    input  logic                                waitrequest,
    output logic [cpu_bus_pkg::data_w-1:0]      writedata,
    output logic [cpu_bus_pkg::byte_en_w-1:0]   byteenable,
    input  logic [cpu_bus_pkg::data_w-1:0]      readdata
);

    import mips_isa_pkg::*;
    import cpu_bus_pkg::*;

    logic [data_w-1:0]       pc;
    logic [data_w-1:0]       next_pc;
    logic [data_w-1:0]       rs_data;
    logic [data_w-1:0]       rt_data;
    logic [data_w-1:0]       alu_result;
    logic [data_w-1:0]       alu_b;
    logic [reg_addr_w-1:0]   rs_addr;
    logic [reg_addr_w-1:0]   rt_addr;
    logic [reg_addr_w-1:0]   rf_waddr;
    logic [data_w-1:0]       rf_wdata;
    logic                    rf_we;
    alu_op_t                 alu_op;
    logic [shamt_w-1:0]      shamt;
    logic                    pc_advance;
    opcode_t                 branch_op;
    funct_t                  funct;
    logic [imm_w-1:0]        imm;
    logic [jump_index_w-1:0] jump_index;

    cpu_control u_cpu_control (
        .clk        (clk),
        .reset      (reset),
        .waitrequest(waitrequest),
        .readdata   (readdata),
        .pc         (pc),
        .next_pc    (next_pc),
        .rt_data    (rt_data),
        .alu_result (alu_result),
        .active     (active),
        .read       (read),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .byteenable (byteenable),
        .rs_addr    (rs_addr),
        .rt_addr    (rt_addr),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .alu_op     (alu_op),
        .alu_b      (alu_b),
        .shamt      (shamt),
        .pc_advance (pc_advance),
        .branch_op  (branch_op),
        .funct      (funct),
        .imm        (imm),
        .jump_index (jump_index)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .reset  (reset),
        .rs_addr(rs_addr),
        .rt_addr(rt_addr),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .rs_data(rs_data),
        .rt_data(rt_data),
        .v0     (register_v0)
    );

    alu u_alu (
        .op    (alu_op),
        .a     (rs_data),
        .b     (alu_b),
        .shamt (shamt),
        .result(alu_result)
    );

    pc_unit #(
        .reset_vector(reset_vector)
    ) u_pc_unit (
        .clk       (clk),
        .reset     (reset),
        .advance   (pc_advance),
        .op        (branch_op),
        .funct     (funct),
        .rs_data   (rs_data),
        .rt_data   (rt_data),
        .imm       (imm),
        .jump_index(jump_index),
        .pc        (pc),
        .next_pc   (next_pc)
    );

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
`default_nettype none

module clock_gen #(
    parameter int half_period = 4
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== testbench/cpu_bus_assertions.sv ====
`default_nettype none

module cpu_bus_assertions #(
    parameter logic [cpu_bus_pkg::data_w-1:0] reset_vector = 32'hBFC0_0000
) (
    input logic                              clk,
    input logic                              reset,
    input logic                              active,
    input logic                              read,
    input logic                              write,
    input logic                              waitrequest,
    input logic [cpu_bus_pkg::data_w-1:0]    address,
    input logic [cpu_bus_pkg::data_w-1:0]    writedata,
    input logic [cpu_bus_pkg::byte_en_w-1:0] byteenable
);

    timeunit 1ns;
    timeprecision 1ps;

    import cpu_bus_pkg::*;

    int error_count = 0;

    // First cycle out of reset fetches from the reset vector
    first_fetch: assert property (@(posedge clk)
        $fell(reset) |-> read && !write && active && address == reset_vector &&
                         byteenable == byte_en_full)
        else begin
            $error("first bus cycle after reset is not a full-word read at the reset vector");
            error_count++;
        end

    one_strobe: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            $error("read and write are high together");
            error_count++;
        end

    // Request held under waitrequest must not move
    held_request: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=>
            $stable(read) && $stable(write) && $stable(address) &&
            $stable(writedata) && $stable(byteenable))
        else begin
            $error("bus request changed while waitrequest was high");
            error_count++;
        end

    halted_quiet: assert property (@(posedge clk) disable iff (reset)
        !active |-> !read && !write)
        else begin
            $error("bus strobe seen after the processor halted");
            error_count++;
        end

    halted_stays: assert property (@(posedge clk) disable iff (reset) !active |=> !active)
        else begin
            $error("active rose again without a reset");
            error_count++;
        end

endmodule

bind mips_cpu_bus cpu_bus_assertions #(
    .reset_vector(reset_vector)
) u_cpu_bus_assertions (
    .clk        (clk),
    .reset      (reset),
    .active     (active),
    .read       (read),
    .write      (write),
    .waitrequest(waitrequest),
    .address    (address),
    .writedata  (writedata),
    .byteenable (byteenable)
);

`default_nettype wire

// ==== testbench/tb_mips_cpu_bus.sv ====
`default_nettype none

module tb_mips_cpu_bus;

    timeunit 1ns;
    timeprecision 1ps;

    import mips_isa_pkg::*;

    localparam logic [31:0] reset_vector = 32'hBFC0_0000;

    logic        clk;
    logic        reset;
    logic        waitrequest;
    logic [31:0] readdata;
    logic        active;
    logic [31:0] register_v0;
    logic [31:0] address;
    logic        write;
    logic        read;
    logic [31:0] writedata;
    logic [3:0]  byteenable;

    // Word memory covering the 1 KB window at the reset vector
    logic [31:0] mem [256];
    logic [31:0] exp_addr [$];
    logic [31:0] exp_data [$];
    logic [31:0] exp_v0;
    logic [31:0] rng = 32'h43ab_cae3;
    int          n_instr;
    int          wait_left;
    bit          in_transfer;
    int          errors = 0;
    int          proto_errors;
    int          cycles;
    int          timeout_cycles;

    clock_gen u_clock_gen (.clk(clk));

    mips_cpu_bus #(
        .reset_vector(reset_vector)
    ) u_mips_cpu_bus (
        .clk        (clk),
        .reset      (reset),
        .active     (active),
        .register_v0(register_v0),
        .address    (address),
        .write      (write),
        .read       (read),
        .waitrequest(waitrequest),
        .writedata  (writedata),
        .byteenable (byteenable),
        .readdata   (readdata)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] r_word(funct_t f, int rs, int rt, int rd, int sh);
        return {6'h00, rs[4:0], rt[4:0], rd[4:0], sh[4:0], f};
    endfunction

    function automatic logic [31:0] i_word(opcode_t op, int rs, int rt, int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    function automatic logic [31:0] j_word(int idx);
        logic [31:0] target;
        target = reset_vector + 32'(idx * 4);
        return {op_j, target[27:2]};
    endfunction

    task automatic emit(input logic [31:0] w);
        mem[n_instr] = w;
        n_instr++;
    endtask

    task automatic load_program();
        funct_t  r_ops [10] = '{fn_addu, fn_subu, fn_and, fn_or, fn_xor,
                                fn_slt, fn_sltu, fn_sll, fn_srl, fn_sra};
        opcode_t i_ops [6]  = '{op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui};
        int      off;
        for (int i = 0; i < 256; i++) begin
            mem[i] = (reset_vector + 32'(i * 4)) ^ 32'h5a5a_a5a5;
        end
        mem[128] = 32'h8765_4321;
        mem[129] = 32'h0000_7f3c;
        n_instr = 0;
        off = 'h40;
        // s0 points at the data words and t0 and t1 hold them
        emit(i_word(op_lui, 0, 16, 'hbfc0));
        emit(i_word(op_ori, 16, 16, 'h0200));
        emit(i_word(op_lw, 16, 8, 0));
        emit(i_word(op_lw, 16, 9, 4));
        foreach (r_ops[i]) begin
            emit(r_word(r_ops[i], 9, 8, 12, 4));
            emit(i_word(op_sw, 16, 12, off));
            off += 4;
        end
        foreach (i_ops[i]) begin
            emit(i_word(i_ops[i], 8, 12, 'hff0f));
            emit(i_word(op_sw, 16, 12, off));
            off += 4;
        end
        // Read back the first stored sum
        emit(i_word(op_lw, 16, 13, 'h40));
        emit(r_word(fn_addu, 13, 9, 13, 0));
        emit(i_word(op_sw, 16, 13, off));
        off += 4;
        // Taken BEQ, taken BNE, untaken BEQ, then J, each with a delay slot
        emit(i_word(op_beq, 8, 8, 2));
        emit(i_word(op_addiu, 0, 2, 1));
        emit(i_word(op_addiu, 2, 2, 100));
        emit(i_word(op_bne, 8, 9, 2));
        emit(i_word(op_addiu, 2, 2, 2));
        emit(i_word(op_addiu, 2, 2, 200));
        emit(i_word(op_beq, 8, 9, 3));
        emit(i_word(op_addiu, 2, 2, 4));
        emit(i_word(op_addiu, 2, 2, 8));
        emit(j_word(n_instr + 3));
        emit(i_word(op_addiu, 2, 2, 16));
        emit(i_word(op_addiu, 2, 2, 400));
        emit(i_word(op_sw, 16, 2, off));
        // JR to address zero halts after its delay slot
        emit(r_word(fn_jr, 0, 0, 0, 0));
        emit(i_word(op_addiu, 2, 2, 32));
    endtask

    // Instruction-level model with one delay slot that fills the expected stores
    task automatic run_model();
        logic [31:0] r [32];
        logic [31:0] m [256];
        logic [31:0] pc, npc, p4, ir, a, b, sx, zx, ea, res, target;
        logic [4:0]  dst;
        logic        wr;
        logic        taken;
        int          steps;
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        m = mem;
        pc = reset_vector;
        npc = reset_vector + 4;
        steps = 0;
        while (pc != '0 && steps < 1000) begin
            ir = m[pc[9:2]];
            a = r[ir[25:21]];
            b = r[ir[20:16]];
            sx = {{16{ir[15]}}, ir[15:0]};
            zx = {16'h0000, ir[15:0]};
            ea = a + sx;
            p4 = pc + 4;
            target = p4 + {sx[29:0], 2'b00};
            dst = ir[20:16];
            wr = 1'b1;
            taken = 1'b0;
            res = '0;
            case (ir[31:26])
                op_rtype: begin
                    dst = ir[15:11];
                    case (ir[5:0])
                        fn_addu: res = a + b;
                        fn_subu: res = a - b;
                        fn_and:  res = a & b;
                        fn_or:   res = a | b;
                        fn_xor:  res = a ^ b;
                        fn_slt:  res = {31'b0, $signed(a) < $signed(b)};
                        fn_sltu: res = {31'b0, a < b};
                        fn_sll:  res = b << ir[10:6];
                        fn_srl:  res = b >> ir[10:6];
                        fn_sra:  res = $signed(b) >>> ir[10:6];
                        default: begin
                            wr = 1'b0;
                            taken = 1'b1;
                            target = a;
                        end
                    endcase
                end
                op_addiu: res = a + sx;
                op_slti:  res = {31'b0, $signed(a) < $signed(sx)};
                op_andi:  res = a & zx;
                op_ori:   res = a | zx;
                op_xori:  res = a ^ zx;
                op_lui:   res = {ir[15:0], 16'h0000};
                op_lw:    res = m[ea[9:2]];
                op_sw: begin
                    wr = 1'b0;
                    m[ea[9:2]] = b;
                    exp_addr.push_back(ea);
                    exp_data.push_back(b);
                end
                op_beq: begin
                    wr = 1'b0;
                    taken = (a == b);
                end
                op_bne: begin
                    wr = 1'b0;
                    taken = (a != b);
                end
                op_j: begin
                    wr = 1'b0;
                    taken = 1'b1;
                    target = {p4[31:28], ir[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dst != 0) r[dst] = res;
            pc = npc;
            npc = taken ? target : npc + 4;
            steps++;
        end
        exp_v0 = r[2];
    endtask

    // Memory slave with random wait states per transfer
    always @(negedge clk) begin
        if (!(read || write)) begin
            waitrequest = 1'b1;
            in_transfer = 1'b0;
        end else begin
            if (!in_transfer) begin
                in_transfer = 1'b1;
                rng = xorshift32(rng);
                wait_left = int'(rng % 4);
            end
            if (address[31:10] != reset_vector[31:10]) begin
                $display("Bus access outside the memory window at %0t: %h", $time, address);
                errors++;
            end
            if (wait_left != 0) begin
                waitrequest = 1'b1;
                wait_left--;
            end else begin
                waitrequest = 1'b0;
                if (read) readdata = mem[address[9:2]];
                in_transfer = 1'b0;
            end
        end
    end

    // Completed writes update memory and are checked in order
    always @(posedge clk) begin
        if (!reset && write && !waitrequest) begin
            mem[address[9:2]] = writedata;
            if (exp_addr.size() == 0) begin
                $display("Store at %0t to %h was not expected", $time, address);
                errors++;
            end else begin
                assert (address == exp_addr[0] && writedata == exp_data[0]) else begin
                    $display("Mismatch at %0t: store %h to %h, expected %h to %h", $time,
                             writedata, address, exp_data[0], exp_addr[0]);
                    errors++;
                end
                void'(exp_addr.pop_front());
                void'(exp_data.pop_front());
            end
        end
    end

    initial begin
        reset = 1'b1;
        waitrequest = 1'b1;
        readdata = '0;
        load_program();
        run_model();
        timeout_cycles = 20 * n_instr + 100;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        cycles = 0;
        while (active && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (active) begin
            $display("Processor did not halt within %0d cycles", timeout_cycles);
            errors++;
        end else begin
            repeat (4) @(negedge clk);
            assert (exp_addr.size() == 0) else begin
                $display("%0d expected stores never happened", exp_addr.size());
                errors++;
            end
            assert (register_v0 == exp_v0) else begin
                $display("Mismatch at %0t: register_v0 is %h, expected %h", $time,
                         register_v0, exp_v0);
                errors++;
            end
        end
        proto_errors = u_mips_cpu_bus.u_cpu_bus_assertions.error_count;
        $display("Errors: %0d data, %0d protocol", errors, proto_errors);
        if (errors == 0 && proto_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/mips_isa_pkg.sv
design/cpu_bus_pkg.sv
design/alu.sv
design/reg_file.sv
design/pc_unit.sv
design/cpu_control.sv
design/mips_cpu_bus.sv
testbench/clock_gen.sv
testbench/cpu_bus_assertions.sv
testbench/tb_mips_cpu_bus.sv
